// ==== xbar_pkg.sv ====
// Fixed single-beat read configuration; ADDR_MAP must be edited by hand when NUM_MST or NUM_RULES change
`default_nettype none

package xbar_pkg;

  // Port counts and widths
  localparam int unsigned NUM_SLV       = 2;
  localparam int unsigned NUM_MST       = 3;
  localparam int unsigned ADDR_W        = 32;
  localparam int unsigned DATA_W        = 32;
  localparam int unsigned ID_W          = 4;

  // Outstanding reads per slave port and error responder queue depth
  localparam int unsigned MAX_TRANS     = 4;
  localparam int unsigned ERR_MAX_TRANS = 2;

  // Spill register stages on each connected pair, 0 gives a straight wire
  localparam int unsigned NUM_CUTS      = 1;
  localparam int unsigned NUM_RULES     = 3;

  // One extra code point for the error responder
  localparam int unsigned MST_IDX_W     = $clog2(NUM_MST + 1);

  typedef logic [ADDR_W-1:0]    addr_t;
  typedef logic [DATA_W-1:0]    data_t;
  typedef logic [ID_W-1:0]      id_t;
  typedef logic [MST_IDX_W-1:0] mst_idx_t;

  typedef enum logic [1:0] {
    RESP_OKAY   = 2'b00,
    RESP_DECERR = 2'b11
  } rresp_t;

  // End address is exclusive
  typedef struct packed {
    mst_idx_t idx;
    addr_t    start_addr;
    addr_t    end_addr;
  } rule_t;

  typedef struct packed {
    id_t   id;
    addr_t addr;
  } ar_chan_t;

  typedef struct packed {
    id_t    id;
    data_t  data;
    rresp_t resp;
  } r_chan_t;

  // 4 KiB window per master at 0x1000_0000, 0x2000_0000, 0x3000_0000
  localparam rule_t ADDR_MAP [NUM_RULES] = '{
    '{idx: 2'd0, start_addr: 32'h1000_0000, end_addr: 32'h1000_1000},
    '{idx: 2'd1, start_addr: 32'h2000_0000, end_addr: 32'h2000_1000},
    '{idx: 2'd2, start_addr: 32'h3000_0000, end_addr: 32'h3000_1000}
  };

  // Row per slave port; slave 1 has no path to master 2
  localparam logic [NUM_SLV-1:0][NUM_MST-1:0] CONNECTIVITY = {3'b011, 3'b111};

endpackage

`default_nettype wire

// ==== xbar_spill_reg.sv ====
// One cycle of latency, full throughput; ready_o depends only on internal state
`default_nettype none

module xbar_spill_reg #(
  parameter type payload_t = logic
) (
  input  logic     clk_i,
  input  logic     rst_n_i,

  input  logic     valid_i,
  input  payload_t data_i,
  output logic     ready_o,

  output logic     valid_o,
  output payload_t data_o,
  input  logic     ready_i
);

  logic     a_full_q;
  logic     b_full_q;
  payload_t a_data_q;
  payload_t b_data_q;
  logic     a_fill;
  logic     a_drain;
  logic     b_fill;
  logic     b_drain;

  // Main register A takes input, B catches A when the output stalls
  assign a_fill  = valid_i && ready_o;
  assign a_drain = a_full_q && !b_full_q;
  assign b_fill  = a_drain && !ready_i;
  assign b_drain = b_full_q && ready_i;

  assign ready_o = !a_full_q || !b_full_q;
  assign valid_o = a_full_q || b_full_q;

  // Spilled entry is older, so it leaves first
  assign data_o  = b_full_q ? b_data_q : a_data_q;

  always_ff @(posedge clk_i) begin
    if (a_fill) begin
      a_data_q <= data_i;
    end
    if (b_fill) begin
      b_data_q <= a_data_q;
    end
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      a_full_q <= 1'b0;
      b_full_q <= 1'b0;
    end else begin
      if (a_fill) begin
        a_full_q <= 1'b1;
      end else if (a_drain) begin
        a_full_q <= 1'b0;
      end
      if (b_fill) begin
        b_full_q <= 1'b1;
      end else if (b_drain) begin
        b_full_q <= 1'b0;
      end
    end
  end

endmodule

`default_nettype wire

// ==== xbar_addr_decode.sv ====
// Purely combinational; rules are assumed not to overlap, and unconnected targets decode as error
`default_nettype none

module xbar_addr_decode #(
  parameter int unsigned SLV_IDX = 0
) (
  input  xbar_pkg::addr_t    addr_i,
  output xbar_pkg::mst_idx_t sel_o
);

  logic hit;
  xbar_pkg::mst_idx_t hit_idx;

  // Scan the whole rule table for a range containing the address
  always_comb begin
    hit     = 1'b0;
    hit_idx = '0;
    for (int unsigned k = 0; k < xbar_pkg::NUM_RULES; k++) begin
      if ((addr_i >= xbar_pkg::ADDR_MAP[k].start_addr) &&
          (addr_i <  xbar_pkg::ADDR_MAP[k].end_addr)) begin
        hit     = 1'b1;
        hit_idx = xbar_pkg::ADDR_MAP[k].idx;
      end
    end
  end

  // A mapped address is only routed if this slave port may reach the target
  always_comb begin
    sel_o = xbar_pkg::mst_idx_t'(xbar_pkg::NUM_MST);
    if (hit && xbar_pkg::CONNECTIVITY[SLV_IDX][hit_idx]) begin
      sel_o = hit_idx;
    end
  end

endmodule

`default_nettype wire

// ==== xbar_read_demux.sv ====
// Single target at a time per port; R is only taken from the locked target, so order is kept
`default_nettype none

module xbar_read_demux (
  input  logic                                            clk_i,
  input  logic                                            rst_n_i,

  input  logic                                            slv_ar_valid_i,
  input  xbar_pkg::ar_chan_t                              slv_ar_i,
  input  xbar_pkg::mst_idx_t                              slv_ar_sel_i,
  output logic                                            slv_ar_ready_o,

  output logic                                            slv_r_valid_o,
  output xbar_pkg::r_chan_t                               slv_r_o,
  input  logic                                            slv_r_ready_i,

  output logic               [xbar_pkg::NUM_MST:0]        mst_ar_valid_o,
  output xbar_pkg::ar_chan_t [xbar_pkg::NUM_MST:0]        mst_ar_o,
  input  logic               [xbar_pkg::NUM_MST:0]        mst_ar_ready_i,
  input  logic               [xbar_pkg::NUM_MST:0]        mst_r_valid_i,
  input  xbar_pkg::r_chan_t  [xbar_pkg::NUM_MST:0]        mst_r_i,
  output logic               [xbar_pkg::NUM_MST:0]        mst_r_ready_o
);

  localparam int unsigned CNT_W = $clog2(xbar_pkg::MAX_TRANS + 1);

  typedef logic [CNT_W-1:0] cnt_t;

  cnt_t               cnt_q;
  xbar_pkg::mst_idx_t lock_q;
  logic               busy;
  logic               ar_allowed;
  logic               ar_fire;
  logic               r_fire;

  assign busy = (cnt_q != '0);

  // Block when full, or when switching target with reads still in flight
  assign ar_allowed = (cnt_q != cnt_t'(xbar_pkg::MAX_TRANS)) &&
                      (!busy || (slv_ar_sel_i == lock_q));

  assign slv_ar_ready_o = ar_allowed && mst_ar_ready_i[slv_ar_sel_i];

  // Responses come back only from the target holding the lock
  assign slv_r_valid_o = busy && mst_r_valid_i[lock_q];
  assign slv_r_o       = mst_r_i[lock_q];

  assign ar_fire = slv_ar_valid_i && slv_ar_ready_o;
  assign r_fire  = slv_r_valid_o && slv_r_ready_i;

  always_comb begin
    for (int unsigned k = 0; k <= xbar_pkg::NUM_MST; k++) begin
      mst_ar_valid_o[k] = slv_ar_valid_i && ar_allowed &&
                          (slv_ar_sel_i == xbar_pkg::mst_idx_t'(k));
      mst_ar_o[k]       = slv_ar_i;
      mst_r_ready_o[k]  = slv_r_ready_i && busy && (lock_q == xbar_pkg::mst_idx_t'(k));
    end
  end

  // Outstanding read counter
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      cnt_q <= '0;
    end else begin
      case ({ar_fire, r_fire})
        2'b10:   cnt_q <= cnt_q + cnt_t'(1);
        2'b01:   cnt_q <= cnt_q - cnt_t'(1);
        default: cnt_q <= cnt_q;
      endcase
    end
  end

  // Target of the reads in flight, refreshed on each accepted request
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      lock_q <= '0;
    end else if (ar_fire) begin
      lock_q <= slv_ar_sel_i;
    end
  end

endmodule

`default_nettype wire

// ==== xbar_err_slv.sv ====
// Answers every read with DECERR and zero data; holds at most ERR_MAX_TRANS pending IDs
`default_nettype none

module xbar_err_slv (
  input  logic               clk_i,
  input  logic               rst_n_i,

  input  logic               ar_valid_i,
  input  xbar_pkg::ar_chan_t ar_i,
  output logic               ar_ready_o,

  output logic               r_valid_o,
  output xbar_pkg::r_chan_t  r_o,
  input  logic               r_ready_i
);

  localparam int unsigned DEPTH = xbar_pkg::ERR_MAX_TRANS;
  localparam int unsigned PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int unsigned CNT_W = $clog2(DEPTH + 1);

  typedef logic [PTR_W-1:0] ptr_t;
  typedef logic [CNT_W-1:0] cnt_t;

  xbar_pkg::id_t id_q [DEPTH];
  ptr_t          wr_ptr_q;
  ptr_t          rd_ptr_q;
  cnt_t          cnt_q;
  logic          push;
  logic          pop;

  assign ar_ready_o = (cnt_q != cnt_t'(DEPTH));
  assign r_valid_o  = (cnt_q != '0);

  assign push = ar_valid_i && ar_ready_o;
  assign pop  = r_valid_o && r_ready_i;

  always_comb begin
    r_o      = '0;
    r_o.id   = id_q[rd_ptr_q];
    r_o.resp = xbar_pkg::RESP_DECERR;
  end

  // ID queue storage
  always_ff @(posedge clk_i) begin
    if (push) begin
      id_q[wr_ptr_q] <= ar_i.id;
    end
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      cnt_q    <= '0;
    end else begin
      if (push) begin
        wr_ptr_q <= (wr_ptr_q == ptr_t'(DEPTH - 1)) ? '0 : wr_ptr_q + ptr_t'(1);
      end
      if (pop) begin
        rd_ptr_q <= (rd_ptr_q == ptr_t'(DEPTH - 1)) ? '0 : rd_ptr_q + ptr_t'(1);
      end
      case ({push, pop})
        2'b10:   cnt_q <= cnt_q + cnt_t'(1);
        2'b01:   cnt_q <= cnt_q - cnt_t'(1);
        default: cnt_q <= cnt_q;
      endcase
    end
  end

endmodule

`default_nettype wire

// ==== xbar_unmuxed.sv ====
// Read-only crossbar, one private slot per (master, slave) pair; unconnected slots stay idle
`default_nettype none

module xbar_unmuxed (
  input  logic                                                          clk_i,
  input  logic                                                          rst_n_i,

  input  logic               [xbar_pkg::NUM_SLV-1:0]                    slv_ar_valid_i,
  input  xbar_pkg::ar_chan_t [xbar_pkg::NUM_SLV-1:0]                    slv_ar_i,
  output logic               [xbar_pkg::NUM_SLV-1:0]                    slv_ar_ready_o,
  output logic               [xbar_pkg::NUM_SLV-1:0]                    slv_r_valid_o,
  output xbar_pkg::r_chan_t  [xbar_pkg::NUM_SLV-1:0]                    slv_r_o,
  input  logic               [xbar_pkg::NUM_SLV-1:0]                    slv_r_ready_i,

  output logic               [xbar_pkg::NUM_MST-1:0][xbar_pkg::NUM_SLV-1:0] mst_ar_valid_o,
  output xbar_pkg::ar_chan_t [xbar_pkg::NUM_MST-1:0][xbar_pkg::NUM_SLV-1:0] mst_ar_o,
  input  logic               [xbar_pkg::NUM_MST-1:0][xbar_pkg::NUM_SLV-1:0] mst_ar_ready_i,
  input  logic               [xbar_pkg::NUM_MST-1:0][xbar_pkg::NUM_SLV-1:0] mst_r_valid_i,
  input  xbar_pkg::r_chan_t  [xbar_pkg::NUM_MST-1:0][xbar_pkg::NUM_SLV-1:0] mst_r_i,
  output logic               [xbar_pkg::NUM_MST-1:0][xbar_pkg::NUM_SLV-1:0] mst_r_ready_o
);

  localparam int unsigned NM = xbar_pkg::NUM_MST;
  localparam int unsigned NC = xbar_pkg::NUM_CUTS;

  // Demux side of every slot, index NM is the error responder
  logic               [xbar_pkg::NUM_SLV-1:0][NM:0] dmx_ar_valid;
  xbar_pkg::ar_chan_t [xbar_pkg::NUM_SLV-1:0][NM:0] dmx_ar;
  logic               [xbar_pkg::NUM_SLV-1:0][NM:0] dmx_ar_ready;
  logic               [xbar_pkg::NUM_SLV-1:0][NM:0] dmx_r_valid;
  xbar_pkg::r_chan_t  [xbar_pkg::NUM_SLV-1:0][NM:0] dmx_r;
  logic               [xbar_pkg::NUM_SLV-1:0][NM:0] dmx_r_ready;

  for (genvar s = 0; s < xbar_pkg::NUM_SLV; s++) begin : gen_slv_port
    xbar_pkg::mst_idx_t ar_sel;

    xbar_addr_decode #(
      .SLV_IDX ( s )
    ) xbar_addr_decode_i (
      .addr_i ( slv_ar_i[s].addr ),
      .sel_o  ( ar_sel           )
    );

    xbar_read_demux xbar_read_demux_i (
      .clk_i          ( clk_i             ),
      .rst_n_i        ( rst_n_i           ),
      .slv_ar_valid_i ( slv_ar_valid_i[s] ),
      .slv_ar_i       ( slv_ar_i[s]       ),
      .slv_ar_sel_i   ( ar_sel            ),
      .slv_ar_ready_o ( slv_ar_ready_o[s] ),
      .slv_r_valid_o  ( slv_r_valid_o[s]  ),
      .slv_r_o        ( slv_r_o[s]        ),
      .slv_r_ready_i  ( slv_r_ready_i[s]  ),
      .mst_ar_valid_o ( dmx_ar_valid[s]   ),
      .mst_ar_o       ( dmx_ar[s]         ),
      .mst_ar_ready_i ( dmx_ar_ready[s]   ),
      .mst_r_valid_i  ( dmx_r_valid[s]    ),
      .mst_r_i        ( dmx_r[s]          ),
      .mst_r_ready_o  ( dmx_r_ready[s]    )
    );

    xbar_err_slv xbar_err_slv_i (
      .clk_i      ( clk_i               ),
      .rst_n_i    ( rst_n_i             ),
      .ar_valid_i ( dmx_ar_valid[s][NM] ),
      .ar_i       ( dmx_ar[s][NM]       ),
      .ar_ready_o ( dmx_ar_ready[s][NM] ),
      .r_valid_o  ( dmx_r_valid[s][NM]  ),
      .r_o        ( dmx_r[s][NM]        ),
      .r_ready_i  ( dmx_r_ready[s][NM]  )
    );

    for (genvar m = 0; m < NM; m++) begin : gen_mst_slot
      if (xbar_pkg::CONNECTIVITY[s][m]) begin : gen_connected
        // Stage 0 sits at the demux for AR and at the master slot for R
        logic               [NC:0] ar_valid;
        logic               [NC:0] ar_ready;
        xbar_pkg::ar_chan_t [NC:0] ar_data;
        logic               [NC:0] r_valid;
        logic               [NC:0] r_ready;
        xbar_pkg::r_chan_t  [NC:0] r_data;

        assign ar_valid[0]          = dmx_ar_valid[s][m];
        assign ar_data[0]           = dmx_ar[s][m];
        assign dmx_ar_ready[s][m]   = ar_ready[0];
        assign mst_ar_valid_o[m][s] = ar_valid[NC];
        assign mst_ar_o[m][s]       = ar_data[NC];
        assign ar_ready[NC]         = mst_ar_ready_i[m][s];

        assign r_valid[0]           = mst_r_valid_i[m][s];
        assign r_data[0]            = mst_r_i[m][s];
        assign mst_r_ready_o[m][s]  = r_ready[0];
        assign dmx_r_valid[s][m]    = r_valid[NC];
        assign dmx_r[s][m]          = r_data[NC];
        assign r_ready[NC]          = dmx_r_ready[s][m];

        for (genvar c = 0; c < NC; c++) begin : gen_cut
          xbar_spill_reg #(
            .payload_t ( xbar_pkg::ar_chan_t )
          ) ar_cut_i (
            .clk_i   ( clk_i         ),
            .rst_n_i ( rst_n_i       ),
            .valid_i ( ar_valid[c]   ),
            .data_i  ( ar_data[c]    ),
            .ready_o ( ar_ready[c]   ),
            .valid_o ( ar_valid[c+1] ),
            .data_o  ( ar_data[c+1]  ),
            .ready_i ( ar_ready[c+1] )
          );

          xbar_spill_reg #(
            .payload_t ( xbar_pkg::r_chan_t )
          ) r_cut_i (
            .clk_i   ( clk_i        ),
            .rst_n_i ( rst_n_i      ),
            .valid_i ( r_valid[c]   ),
            .data_i  ( r_data[c]    ),
            .ready_o ( r_ready[c]   ),
            .valid_o ( r_valid[c+1] ),
            .data_o  ( r_data[c+1]  ),
            .ready_i ( r_ready[c+1] )
          );
        end
      end else begin : gen_unconnected
        // Decoder never selects this slot, keep both sides quiet
        assign dmx_ar_ready[s][m]   = 1'b0;
        assign dmx_r_valid[s][m]    = 1'b0;
        assign dmx_r[s][m]          = '0;
        assign mst_ar_valid_o[m][s] = 1'b0;
        assign mst_ar_o[m][s]       = '0;
        assign mst_r_ready_o[m][s]  = 1'b0;
      end
    end
  end

endmodule

`default_nettype wire

// ==== tb_xbar_unmuxed_asserts.sv ====
// Handshake checks bound into the crossbar top level; slot [2][1] is assumed unconnected
`default_nettype none

module tb_xbar_unmuxed_asserts (
  input wire logic                                                          clk_i,
  input wire logic                                                          rst_n_i,
  input wire logic               [xbar_pkg::NUM_MST-1:0][xbar_pkg::NUM_SLV-1:0] mst_ar_valid_o,
  input wire xbar_pkg::ar_chan_t [xbar_pkg::NUM_MST-1:0][xbar_pkg::NUM_SLV-1:0] mst_ar_o,
  input wire logic               [xbar_pkg::NUM_MST-1:0][xbar_pkg::NUM_SLV-1:0] mst_ar_ready_i,
  input wire logic               [xbar_pkg::NUM_SLV-1:0]                    slv_r_valid_o,
  input wire xbar_pkg::r_chan_t  [xbar_pkg::NUM_SLV-1:0]                    slv_r_o,
  input wire logic               [xbar_pkg::NUM_SLV-1:0]                    slv_r_ready_i
);

  for (genvar s = 0; s < xbar_pkg::NUM_SLV; s++) begin : gen_slv
    // R valid and payload hold until the slave side accepts
    assert property (@(posedge clk_i) disable iff (!rst_n_i)
      slv_r_valid_o[s] && !slv_r_ready_i[s] |=> slv_r_valid_o[s] && $stable(slv_r_o[s]))
      else $error("slave R changed before its transfer");

    for (genvar m = 0; m < xbar_pkg::NUM_MST; m++) begin : gen_mst
      assert property (@(posedge clk_i) disable iff (!rst_n_i)
        mst_ar_valid_o[m][s] && !mst_ar_ready_i[m][s] |=>
          mst_ar_valid_o[m][s] && $stable(mst_ar_o[m][s]))
        else $error("master slot AR changed before its transfer");
    end
  end

  // No path from slave 1 to master 2
  assert property (@(posedge clk_i) disable iff (!rst_n_i) !mst_ar_valid_o[2][1])
    else $error("unconnected slot raised AR valid");

endmodule

bind xbar_unmuxed tb_xbar_unmuxed_asserts asserts_i (
  .clk_i          ( clk_i          ),
  .rst_n_i        ( rst_n_i        ),
  .mst_ar_valid_o ( mst_ar_valid_o ),
  .mst_ar_o       ( mst_ar_o       ),
  .mst_ar_ready_i ( mst_ar_ready_i ),
  .slv_r_valid_o  ( slv_r_valid_o  ),
  .slv_r_o        ( slv_r_o        ),
  .slv_r_ready_i  ( slv_r_ready_i  )
);

`default_nettype wire

// ==== tb_xbar_unmuxed.sv ====
// Self-checking testbench; master models answer in order per slot and slave R ready toggles randomly
`default_nettype none

module tb_xbar_unmuxed;

  localparam int NS    = xbar_pkg::NUM_SLV;
  localparam int NM    = xbar_pkg::NUM_MST;
  localparam int DEPTH = 64;
  localparam int SLOTS = 8;
  localparam int LIMIT = 5000;

  logic clk_i;
  logic rst_n_i;

  logic               [NS-1:0]         slv_ar_valid;
  xbar_pkg::ar_chan_t [NS-1:0]         slv_ar;
  logic               [NS-1:0]         slv_ar_ready;
  logic               [NS-1:0]         slv_r_valid;
  xbar_pkg::r_chan_t  [NS-1:0]         slv_r;
  logic               [NS-1:0]         slv_r_ready;
  logic               [NM-1:0][NS-1:0] mst_ar_valid;
  xbar_pkg::ar_chan_t [NM-1:0][NS-1:0] mst_ar;
  logic               [NM-1:0][NS-1:0] mst_ar_ready;
  logic               [NM-1:0][NS-1:0] mst_r_valid;
  xbar_pkg::r_chan_t  [NM-1:0][NS-1:0] mst_r;
  logic               [NM-1:0][NS-1:0] mst_r_ready;

  // Requests waiting to be issued, and expected responses per slave port
  xbar_pkg::ar_chan_t send_buf [NS][DEPTH];
  int                 send_wr  [NS];
  int                 send_rd  [NS];
  xbar_pkg::r_chan_t  exp_buf  [NS][DEPTH];
  int                 exp_wr   [NS];
  int                 exp_rd   [NS];
  // Accepted requests held by each master model
  xbar_pkg::ar_chan_t slot_buf [NM][NS][SLOTS];
  int                 slot_head [NM][NS];
  int                 slot_tail [NM][NS];

  int    seed = 76129;
  int    mismatch_errs = 0;
  int    other_errs = 0;
  string test_name = "reset";

  xbar_unmuxed xbar_unmuxed_i (
    .clk_i          ( clk_i        ),
    .rst_n_i        ( rst_n_i      ),
    .slv_ar_valid_i ( slv_ar_valid ),
    .slv_ar_i       ( slv_ar       ),
    .slv_ar_ready_o ( slv_ar_ready ),
    .slv_r_valid_o  ( slv_r_valid  ),
    .slv_r_o        ( slv_r        ),
    .slv_r_ready_i  ( slv_r_ready  ),
    .mst_ar_valid_o ( mst_ar_valid ),
    .mst_ar_o       ( mst_ar       ),
    .mst_ar_ready_i ( mst_ar_ready ),
    .mst_r_valid_i  ( mst_r_valid  ),
    .mst_r_i        ( mst_r        ),
    .mst_r_ready_o  ( mst_r_ready  )
  );

  initial begin
    clk_i = 1'b0;
    forever #4 clk_i = ~clk_i;
  end

  // Target index from the address map or NUM_MST for a decode error
  function automatic xbar_pkg::mst_idx_t expected_target(int s, xbar_pkg::addr_t addr);
    xbar_pkg::mst_idx_t tgt;
    tgt = xbar_pkg::mst_idx_t'(NM);
    for (int k = 0; k < xbar_pkg::NUM_RULES; k++) begin
      if (addr >= xbar_pkg::ADDR_MAP[k].start_addr && addr < xbar_pkg::ADDR_MAP[k].end_addr) begin
        if (xbar_pkg::CONNECTIVITY[s][xbar_pkg::ADDR_MAP[k].idx]) begin
          tgt = xbar_pkg::ADDR_MAP[k].idx;
        end
      end
    end
    return tgt;
  endfunction

  function automatic xbar_pkg::data_t model_data(int m, xbar_pkg::addr_t addr);
    return {8'(m), addr[23:0]};
  endfunction

  function automatic xbar_pkg::r_chan_t expected_resp(int s, xbar_pkg::ar_chan_t ar);
    xbar_pkg::r_chan_t  res;
    xbar_pkg::mst_idx_t tgt;
    tgt    = expected_target(s, ar.addr);
    res.id = ar.id;
    if (tgt == xbar_pkg::mst_idx_t'(NM)) begin
      res.data = '0;
      res.resp = xbar_pkg::RESP_DECERR;
    end else begin
      res.data = model_data(int'(tgt), ar.addr);
      res.resp = xbar_pkg::RESP_OKAY;
    end
    return res;
  endfunction

  task automatic check_r(string name, xbar_pkg::r_chan_t exp, xbar_pkg::r_chan_t act);
    if (exp.id !== act.id || exp.data !== act.data || exp.resp !== act.resp) begin
      $display("Mismatch %s: expected id=%h data=%h resp=%0d, actual id=%h data=%h resp=%0d",
               name, exp.id, exp.data, exp.resp, act.id, act.data, act.resp);
      mismatch_errs++;
    end
  endtask

  task automatic check_route(string name, xbar_pkg::mst_idx_t exp, xbar_pkg::mst_idx_t act);
    if (exp !== act) begin
      $display("Mismatch %s: expected target %0d, actual target %0d", name, exp, act);
      mismatch_errs++;
    end
  endtask

  // Slave port drivers and the response comparison
  always @(posedge clk_i) begin
    if (!rst_n_i) begin
      slv_ar_valid <= '0;
      slv_ar       <= '0;
      slv_r_ready  <= '0;
    end else begin
      for (int s = 0; s < NS; s++) begin
        if (slv_ar_valid[s] && slv_ar_ready[s]) begin
          exp_buf[s][exp_wr[s] % DEPTH] = expected_resp(s, slv_ar[s]);
          exp_wr[s] = exp_wr[s] + 1;
          send_rd[s] = send_rd[s] + 1;
        end
        if (slv_r_valid[s] && slv_r_ready[s]) begin
          if (exp_rd[s] == exp_wr[s]) begin
            $display("Slave port %0d returned a response that was never requested", s);
            other_errs++;
          end else begin
            check_r(test_name, exp_buf[s][exp_rd[s] % DEPTH], slv_r[s]);
            exp_rd[s] = exp_rd[s] + 1;
          end
        end
        if (!slv_ar_valid[s] || slv_ar_ready[s]) begin
          if (send_rd[s] != send_wr[s]) begin
            slv_ar_valid[s] <= 1'b1;
            slv_ar[s]       <= send_buf[s][send_rd[s] % DEPTH];
          end else begin
            slv_ar_valid[s] <= 1'b0;
          end
        end
        slv_r_ready[s] <= ($random(seed) & 3) != 0;
      end
    end
  end

  // Master models with random AR ready and random R delay
  always @(posedge clk_i) begin
    if (!rst_n_i) begin
      mst_ar_ready <= '0;
      mst_r_valid  <= '0;
      mst_r        <= '0;
    end else begin
      for (int m = 0; m < NM; m++) begin
        for (int s = 0; s < NS; s++) begin
          if (mst_ar_valid[m][s] && mst_ar_ready[m][s]) begin
            check_route(test_name, expected_target(s, mst_ar[m][s].addr),
                        xbar_pkg::mst_idx_t'(m));
            if (slot_tail[m][s] - slot_head[m][s] >= SLOTS) begin
              $display("Master slot %0d/%0d holds more reads than its model can store", m, s);
              other_errs++;
            end
            slot_buf[m][s][slot_tail[m][s] % SLOTS] = mst_ar[m][s];
            slot_tail[m][s] = slot_tail[m][s] + 1;
          end
          if (mst_r_valid[m][s] && mst_r_ready[m][s]) begin
            slot_head[m][s] = slot_head[m][s] + 1;
          end
          if (!mst_r_valid[m][s] || mst_r_ready[m][s]) begin
            if (slot_head[m][s] != slot_tail[m][s] && ($random(seed) & 3) != 0) begin
              mst_r_valid[m][s]   <= 1'b1;
              mst_r[m][s].id      <= slot_buf[m][s][slot_head[m][s] % SLOTS].id;
              mst_r[m][s].data    <= model_data(m, slot_buf[m][s][slot_head[m][s] % SLOTS].addr);
              mst_r[m][s].resp    <= xbar_pkg::RESP_OKAY;
            end else begin
              mst_r_valid[m][s] <= 1'b0;
            end
          end
          mst_ar_ready[m][s] <= ($random(seed) & 3) != 0;
        end
      end
    end
  end

  task automatic queue_read(int s, xbar_pkg::addr_t addr);
    xbar_pkg::ar_chan_t ar;
    ar.id   = xbar_pkg::id_t'($random(seed));
    ar.addr = addr;
    send_buf[s][send_wr[s] % DEPTH] = ar;
    send_wr[s] = send_wr[s] + 1;
  endtask

  // Mapped, unmapped, or just past the end of a rule
  function automatic xbar_pkg::addr_t random_addr(int sel, int off);
    xbar_pkg::addr_t base;
    base = 32'h1000_0000 * ((sel % 3) + 1);
    if (sel < 3) return base + xbar_pkg::addr_t'((off & 32'h3ff) << 2);
    else if (sel == 3) return 32'h4000_0000 + xbar_pkg::addr_t'(off & 32'hfff);
    else return base + 32'h1000;
  endfunction

  task automatic wait_drained(string what);
    int cycles;
    cycles = 0;
    while ((send_rd[0] != send_wr[0] || exp_rd[0] != exp_wr[0] ||
            send_rd[1] != send_wr[1] || exp_rd[1] != exp_wr[1]) && cycles < LIMIT) begin
      @(negedge clk_i);
      cycles++;
    end
    if (cycles >= LIMIT) begin
      $display("Timeout: reads of %s did not all complete", what);
      other_errs++;
    end
  endtask

  initial begin
    rst_n_i <= 1'b0;
    slv_ar_valid <= '0;
    slv_ar <= '0;
    slv_r_ready <= '0;
    mst_ar_ready <= '0;
    mst_r_valid <= '0;
    mst_r <= '0;
    for (int s = 0; s < NS; s++) begin
      send_wr[s] = 0;
      send_rd[s] = 0;
      exp_wr[s]  = 0;
      exp_rd[s]  = 0;
    end
    for (int m = 0; m < NM; m++) begin
      for (int s = 0; s < NS; s++) begin
        slot_head[m][s] = 0;
        slot_tail[m][s] = 0;
      end
    end
    repeat (5) @(posedge clk_i);
    rst_n_i <= 1'b1;
    @(negedge clk_i);

    test_name = "connected_rules";
    for (int s = 0; s < NS; s++) begin
      for (int m = 0; m < NM; m++) begin
        if (xbar_pkg::CONNECTIVITY[s][m]) queue_read(s, random_addr(m, $random(seed)));
      end
    end
    wait_drained(test_name);

    test_name = "unmapped";
    queue_read(0, 32'h0000_1000);
    queue_read(1, 32'h1000_2000);
    wait_drained(test_name);

    test_name = "unconnected_pair";
    queue_read(1, 32'h3000_0010);
    wait_drained(test_name);

    test_name = "back_to_back";
    for (int i = 0; i < 3 * xbar_pkg::MAX_TRANS; i++) queue_read(0, random_addr(1, i));
    wait_drained(test_name);

    test_name = "random_mix";
    for (int i = 0; i < 24; i++) begin
      queue_read(0, random_addr(i % 5, $random(seed)));
      queue_read(1, random_addr($unsigned($random(seed)) % 5, $random(seed)));
    end
    wait_drained(test_name);

    $display("Errors: %0d mismatches, %0d other", mismatch_errs, other_errs);
    if (mismatch_errs == 0 && other_errs == 0) begin
      $display("=== PASS ===");
    end else begin
      $display("=== FAIL ===");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== src.f ====
xbar_pkg.sv
xbar_spill_reg.sv
xbar_addr_decode.sv
xbar_read_demux.sv
xbar_err_slv.sv
xbar_unmuxed.sv
tb_xbar_unmuxed_asserts.sv
tb_xbar_unmuxed.sv

// ==== run.sh ====
#!/usr/bin/env bash
# Build and run the crossbar testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --assert --timing \
  --top-module tb_xbar_unmuxed \
  -Mdir obj_dir \
  -f src.f
if [ $? -ne 0 ]; then
  echo "Build failed"
  exit 1
fi

./obj_dir/Vtb_xbar_unmuxed > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -qx "=== PASS ===" "$LOG"; then
  exit 0
else
  exit 1
fi
